//--- Bender.yml
package:
  name: fetch_unit

sources:
  # design
  - hdl/fetch_pkg.sv
  - hdl/ibuf_lines.sv
  - hdl/fetch_pointer.sv
  - hdl/packet_rotator.sv
  - hdl/fetch_unit.sv

  # testbench, top module fetch_tb
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/fetch_chk.sv
      - dv/fetch_tb.sv

//--- dv/fetch_chk.sv
`timescale 1ns/1ns

module fetch_chk (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::ibuf_fill_t   fill,
    input  fetch_pkg::cf_req_t      cf,
    input  fetch_pkg::length_t      length,
    input  logic                    stall,
    input  fetch_pkg::idtr_req_t    idtr,
    input  fetch_pkg::line_t        packet,
    input  logic                    packet_valid,
    input  fetch_pkg::bip_t         old_bip,
    input  fetch_pkg::bip_t         new_bip
);

    import fetch_pkg::*;

    int unsigned            fail_count = 0;

    // shadow buffer, one entry per byte
    logic [7:0]             shadow_mem [buf_bytes];
    logic [num_lines-1:0]   shadow_valid;

    bip_t                   exp_new_bip;
    line_t                  exp_packet;
    logic                   exp_window;
    logic                   exp_valid;
    int                     old_line_num;
    int                     new_line_num;

    bip_t                   prev_new_bip;
    bip_t                   prev_old_bip;
    logic                   prev_advance;
    logic                   prev_stall;

    ////////////////////
    // reference model
    always_comb begin
        if (cf.init) begin
            exp_new_bip = cf.init_bip;
        end else if (cf.resteer) begin
            exp_new_bip = cf.wb_bip;
        end else if (cf.branch) begin
            exp_new_bip = cf.bp_bip;
        end else begin
            exp_new_bip = bip_t'((int'(old_bip) + int'(length)) % buf_bytes);
        end
    end

    // packet byte k is buffer byte (bip + k) mod 64
    always_comb begin
        for (int k = 0; k < line_bytes; k++) begin
            exp_packet[8*k +: 8] = shadow_mem[(int'(exp_new_bip) + k) % buf_bytes];
        end
    end

    assign new_line_num = int'(exp_new_bip) / line_bytes;
    assign old_line_num = int'(old_bip) / line_bytes;

    assign exp_window = shadow_valid[new_line_num] &&
                        shadow_valid[(new_line_num + 1) % num_lines];
    assign exp_valid  = (exp_window && !idtr.ie_pending) || idtr.select;

    always_ff @(posedge clk) begin
        if (fill.en) begin
            for (int k = 0; k < line_bytes; k++) begin
                shadow_mem[int'(fill.line_idx) * line_bytes + k] <= fill.data[8*k +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow_valid <= '0;
            prev_new_bip <= '0;
            prev_old_bip <= '0;
            prev_advance <= 1'b0;
            prev_stall   <= 1'b0;
        end else begin
            if (exp_valid && !stall && (old_line_num != new_line_num)) begin
                shadow_valid[old_line_num] <= 1'b0;
            end
            // a fill to the line being left keeps it valid
            if (fill.en) begin
                shadow_valid[fill.line_idx] <= 1'b1;
            end
            prev_new_bip <= exp_new_bip;
            prev_old_bip <= old_bip;
            prev_advance <= exp_valid && !stall;
            prev_stall   <= stall;
        end
    end

    ////////////////////
    // reset state
    a_reset_bip: assert property (@(posedge clk) !rst_n |-> old_bip == '0)
        else begin
            $error("error at %0t: old_bip is %0h, expected 0", $time, $sampled(old_bip));
            fail_count++;
        end

    a_reset_valid: assert property (@(posedge clk) !rst_n && !idtr.select |-> !packet_valid)
        else begin
            $error("error at %0t: packet_valid is 1, expected 0", $time);
            fail_count++;
        end

    ////////////////////
    // pointer register
    a_bip_advance: assert property (@(posedge clk) disable iff (!rst_n)
        prev_advance |-> old_bip == prev_new_bip)
        else begin
            $error("error at %0t: old_bip is %0h, expected %0h", $time,
                $sampled(old_bip), $sampled(prev_new_bip));
            fail_count++;
        end

    a_bip_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !prev_advance |-> old_bip == prev_old_bip)
        else begin
            $error("error at %0t: old_bip is %0h, expected %0h", $time,
                $sampled(old_bip), $sampled(prev_old_bip));
            fail_count++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prev_stall |-> old_bip == prev_old_bip)
        else begin
            $error("error at %0t: old_bip is %0h after stall, expected %0h", $time,
                $sampled(old_bip), $sampled(prev_old_bip));
            fail_count++;
        end

    a_new_bip: assert property (@(posedge clk) disable iff (!rst_n)
        new_bip == exp_new_bip)
        else begin
            $error("error at %0t: new_bip is %0h, expected %0h", $time,
                $sampled(new_bip), $sampled(exp_new_bip));
            fail_count++;
        end

    ////////////////////
    // packet data and valid
    a_packet_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        !idtr.select |-> packet === exp_packet)
        else begin
            $error("error at %0t: packet is %h, expected %h", $time,
                $sampled(packet), $sampled(exp_packet));
            fail_count++;
        end

    a_packet_valid: assert property (@(posedge clk) disable iff (!rst_n)
        packet_valid == exp_valid)
        else begin
            $error("error at %0t: packet_valid is %0b, expected %0b", $time,
                $sampled(packet_valid), $sampled(exp_valid));
            fail_count++;
        end

    a_idtr_override: assert property (@(posedge clk) disable iff (!rst_n)
        idtr.select |-> packet == idtr.packet)
        else begin
            $error("error at %0t: packet is %h, expected %h", $time,
                $sampled(packet), $sampled(idtr.packet));
            fail_count++;
        end

endmodule

bind fetch_unit fetch_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .fill         (fill),
    .cf           (cf),
    .length       (length),
    .stall        (stall),
    .idtr         (idtr),
    .packet       (packet),
    .packet_valid (packet_valid),
    .old_bip      (old_bip),
    .new_bip      (new_bip)
);

//--- dv/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    import fetch_pkg::*;

    localparam int period_ns    = 100;
    localparam int reset_cycles = 10;
    localparam int num_cycles   = 2000;
    localparam int watchdog_ns  = (reset_cycles + num_cycles + 20) * period_ns;

    logic         clk;
    logic         rst_n;
    ibuf_fill_t   fill;
    cf_req_t      cf;
    length_t      length;
    logic         stall;
    idtr_req_t    idtr;
    line_t        packet;
    logic         packet_valid;
    bip_t         old_bip;
    bip_t         new_bip;

    logic [31:0]  lfsr_state = 32'h024c_b745;

    tb_clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_unit uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill         (fill),
        .cf           (cf),
        .length       (length),
        .stall        (stall),
        .idtr         (idtr),
        .packet       (packet),
        .packet_valid (packet_valid),
        .old_bip      (old_bip),
        .new_bip      (new_bip)
    );

    ////////////////////
    // random source
    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic line_t take_line();
        line_t l;
        for (int w = 0; w < line_bytes / 4; w++) begin
            l[32*w +: 32] = take_bits(32);
        end
        return l;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    ////////////////////
    // per-cycle stimulus
    task automatic drive_cycle(input int cycle);
        fill.en       = (take_bits(1) != 0);
        fill.line_idx = line_idx_t'(take_bits(2));
        if (fill.en) begin
            fill.data = take_line();
        end else begin
            fill.data = '0;
        end

        length = length_t'(take_bits(4));
        if (length == 0) begin
            length = 8'd1;
        end

        // sparse redirects, rarer as priority rises
        cf.branch  = (take_bits(3) == 0);
        cf.bp_bip  = bip_t'(take_bits(6));
        cf.resteer = (take_bits(4) == 0);
        cf.wb_bip  = bip_t'(take_bits(6));
        cf.init    = (take_bits(5) == 0);
        cf.init_bip = bip_t'(take_bits(6));
        if (cycle % 50 == 25) begin
            cf.branch  = 1'b1;
            cf.resteer = 1'b1;
            cf.init    = 1'b1;
        end

        stall = (take_bits(2) == 0);

        idtr.ie_pending = (take_bits(4) == 0);
        idtr.select     = (take_bits(5) == 0);
        if (idtr.select) begin
            idtr.packet = take_line();
        end else begin
            idtr.packet = '0;
        end
    endtask

    ////////////////////
    // assertion failures from the bound checker
    always @(negedge clk) begin
        if (uut.u_chk.fail_count != 0) begin
            report_failure("a checker assertion failed");
        end
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog timer expired before the run finished");
    end

    initial begin
        fill   = '0;
        cf     = '0;
        length = 8'd1;
        stall  = 1'b0;
        idtr   = '0;

        wait (rst_n === 1'b1);
        for (int c = 0; c < num_cycles; c++) begin
            @(negedge clk);
            drive_cycle(c);
        end

        // one more edge so the last cycle gets checked
        @(negedge clk);
        if (uut.u_chk.fail_count != 0) begin
            report_failure("a checker assertion failed in the last cycle");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////
    // buffer geometry
    localparam int line_bytes = 16;
    localparam int num_lines = 4;
    localparam int buf_bytes = line_bytes * num_lines;
    localparam int line_width = 8 * line_bytes;
    localparam int bip_width = $clog2(buf_bytes);
    localparam int idx_width = $clog2(num_lines);

    // upper bits pick the line, lower bits the byte in it
    typedef logic [bip_width-1:0] bip_t;
    typedef logic [idx_width-1:0] line_idx_t;

    // byte k sits in bits 8k+7:8k, little-endian
    typedef logic [line_width-1:0] line_t;

    // only the low bip_width bits matter after wrapping
    typedef logic [7:0] length_t;

    ////////////////////
    // next-bip source, in rising priority
    typedef enum logic [1:0] {
        cf_seq     = 2'd0,
        cf_branch  = 2'd1,
        cf_resteer = 2'd2,
        cf_init    = 2'd3
    } cf_src_e;

    typedef struct packed {
        logic init;
        bip_t init_bip;
        logic resteer;
        bip_t wb_bip;
        logic branch;
        bip_t bp_bip;
    } cf_req_t;

    typedef struct packed {
        logic      en;
        line_idx_t line_idx;
        line_t     data;
    } ibuf_fill_t;

    typedef struct packed {
        logic  select;
        logic  ie_pending;
        line_t packet;
    } idtr_req_t;

    // line that holds a given byte pointer
    function automatic line_idx_t bip_line(bip_t bip);
        return bip[bip_width-1 -: idx_width];
    endfunction

endpackage

//--- hdl/fetch_pointer.sv
`timescale 1ns/1ns

module fetch_pointer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fetch_pkg::cf_req_t   cf,
    input  fetch_pkg::length_t   length,
    input  logic                 advance,
    output fetch_pkg::bip_t      old_bip,
    output fetch_pkg::bip_t      new_bip
);

    import fetch_pkg::*;

    cf_src_e     src;
    logic [7:0]  seq_sum;
    bip_t        seq_bip;

    ////////////////////
    // control-flow priority
    // init beats resteer, resteer beats a taken branch
    always_comb begin
        if (cf.init) begin
            src = cf_init;
        end else if (cf.resteer) begin
            src = cf_resteer;
        end else if (cf.branch) begin
            src = cf_branch;
        end else begin
            src = cf_seq;
        end
    end

    ////////////////////
    // sequential next pointer
    // full 8-bit add, upper bits drop off at the wrap
    assign seq_sum = {{(8 - bip_width){1'b0}}, old_bip} + length;
    assign seq_bip = seq_sum[bip_width-1:0];

    always_comb begin
        case (src)
            cf_init: begin
                new_bip = cf.init_bip;
            end
            cf_resteer: begin
                new_bip = cf.wb_bip;
            end
            cf_branch: begin
                new_bip = cf.bp_bip;
            end
            default: begin
                new_bip = seq_bip;
            end
        endcase
    end

    ////////////////////
    // bip register
    // loads only when the current packet is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            old_bip <= '0;
        end else if (advance) begin
            old_bip <= new_bip;
        end
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::ibuf_fill_t   fill,
    input  fetch_pkg::cf_req_t      cf,
    input  fetch_pkg::length_t      length,
    input  logic                    stall,
    input  fetch_pkg::idtr_req_t    idtr,
    output fetch_pkg::line_t        packet,
    output logic                    packet_valid,
    output fetch_pkg::bip_t         old_bip,
    output fetch_pkg::bip_t         new_bip
);

    import fetch_pkg::*;

    line_t                  lines [num_lines];
    logic [num_lines-1:0]   line_valid;
    logic                   advance;

    // packet taken by decode this cycle
    assign advance = packet_valid && !stall;

    ////////////////////
    // instruction buffer lines
    ibuf_lines u_lines (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill       (fill),
        .advance    (advance),
        .old_bip    (old_bip),
        .new_bip    (new_bip),
        .lines      (lines),
        .line_valid (line_valid)
    );

    ////////////////////
    // byte pointer
    fetch_pointer u_pointer (
        .clk     (clk),
        .rst_n   (rst_n),
        .cf      (cf),
        .length  (length),
        .advance (advance),
        .old_bip (old_bip),
        .new_bip (new_bip)
    );

    ////////////////////
    // packet alignment
    packet_rotator u_rotator (
        .lines        (lines),
        .line_valid   (line_valid),
        .new_bip      (new_bip),
        .idtr         (idtr),
        .packet       (packet),
        .packet_valid (packet_valid)
    );

endmodule

//--- hdl/ibuf_lines.sv
`timescale 1ns/1ns

module ibuf_lines (
    input  logic                               clk,
    input  logic                               rst_n,
    input  fetch_pkg::ibuf_fill_t              fill,
    input  logic                               advance,
    input  fetch_pkg::bip_t                    old_bip,
    input  fetch_pkg::bip_t                    new_bip,
    output fetch_pkg::line_t                   lines [fetch_pkg::num_lines],
    output logic [fetch_pkg::num_lines-1:0]    line_valid
);

    import fetch_pkg::*;

    line_idx_t              old_line;
    line_idx_t              new_line;
    logic                   crossing;
    logic [num_lines-1:0]   fill_hit;
    logic [num_lines-1:0]   leave_hit;

    assign old_line = bip_line(old_bip);
    assign new_line = bip_line(new_bip);

    // pointer moves into another line this cycle
    assign crossing = advance && (old_line != new_line);

    always_comb begin
        for (int i = 0; i < num_lines; i++) begin
            fill_hit[i]  = fill.en && (fill.line_idx == line_idx_t'(i));
            leave_hit[i] = crossing && (old_line == line_idx_t'(i));
        end
    end

    ////////////////////
    // line data, written only by the fill port
    always_ff @(posedge clk) begin
        if (fill.en) begin
            lines[fill.line_idx] <= fill.data;
        end
    end

    ////////////////////
    // valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else begin
            for (int i = 0; i < num_lines; i++) begin
                // a fill to the line being left keeps it valid
                if (fill_hit[i]) begin
                    line_valid[i] <= 1'b1;
                end else if (leave_hit[i]) begin
                    line_valid[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hdl/packet_rotator.sv
`timescale 1ns/1ns

module packet_rotator (
    input  fetch_pkg::line_t                   lines [fetch_pkg::num_lines],
    input  logic [fetch_pkg::num_lines-1:0]    line_valid,
    input  fetch_pkg::bip_t                    new_bip,
    input  fetch_pkg::idtr_req_t               idtr,
    output fetch_pkg::line_t                   packet,
    output logic                               packet_valid
);

    import fetch_pkg::*;

    localparam int ring_width = 8 * buf_bytes;

    // one entry per shift stage, entry 0 is the unrotated ring
    logic [ring_width-1:0]  ring_stage [bip_width+1];
    line_t                  buf_packet;
    line_idx_t              cur_line;
    line_idx_t              nxt_line;
    logic                   window_valid;
    logic                   fetch_valid;

    ////////////////////
    // 64-byte ring
    // line i occupies ring bytes 16i to 16i+15
    always_comb begin
        for (int i = 0; i < num_lines; i++) begin
            ring_stage[0][i*line_width +: line_width] = lines[i];
        end
    end

    // stage s moves the ring down by 2^s bytes when bip bit s is set
    // so byte k of the result is ring byte (bip + k) mod 64
    for (genvar s = 0; s < bip_width; s++) begin : g_shift
        localparam int shift_bits = 8 * (1 << s);

        assign ring_stage[s+1] = new_bip[s] ?
            {ring_stage[s][shift_bits-1:0], ring_stage[s][ring_width-1:shift_bits]} :
            ring_stage[s];
    end

    // low 16 bytes form the packet
    assign buf_packet = ring_stage[bip_width][line_width-1:0];

    ////////////////////
    // window validity
    // an instruction may spill into the following line, so both must be there
    assign cur_line = bip_line(new_bip);
    assign nxt_line = cur_line + 1'b1;

    assign window_valid = line_valid[cur_line] && line_valid[nxt_line];

    // interrupt at writeback hides the buffer packet
    assign fetch_valid = window_valid && !idtr.ie_pending;

    ////////////////////
    // interrupt-descriptor override
    assign packet       = idtr.select ? idtr.packet : buf_packet;
    assign packet_valid = fetch_valid || idtr.select;

endmodule

//--- list.f
hdl/fetch_pkg.sv
hdl/ibuf_lines.sv
hdl/fetch_pointer.sv
hdl/packet_rotator.sv
hdl/fetch_unit.sv
dv/tb_clock_gen.sv
dv/fetch_chk.sv
dv/fetch_tb.sv
